// File: include/barrel_macros.svh
`ifndef BARREL_MACROS_SVH
`define BARREL_MACROS_SVH

//////////////////////////////////////////////////
// Core sizing
//////////////////////////////////////////////////

// Hardware threads in the barrel, at least 2
`define BC_NUM_THREADS 4

// Architectural registers per thread
`define BC_NUM_REGS 32

// Data and instruction word width
`define BC_XLEN 32

// Start address distance between two threads
`define BC_PC_STRIDE 32'h0000_0400

`endif

// File: verilog/barrel_pkg.sv
`include "barrel_macros.svh"

package barrel_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int unsigned TID_W  = $clog2(`BC_NUM_THREADS);
    localparam int unsigned RADR_W = $clog2(`BC_NUM_REGS);

    // Thread number
    typedef logic [TID_W-1:0]    tid_t;
    // Register index
    typedef logic [RADR_W-1:0]   reg_addr_t;
    // Data word
    typedef logic [`BC_XLEN-1:0] xlen_t;
    // Instruction address
    typedef logic [`BC_XLEN-1:0] pc_t;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // ALU operations, kept contiguous
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

endpackage

// File: verilog/barrel_if.sv
`timescale 1ns/10ps

//////////////////////////////////////////////////
// Decode to issue
//////////////////////////////////////////////////
interface dec_if import barrel_pkg::*; ();
    logic      vld;
    tid_t      tid;
    alu_op_e   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     imm;
    // Operand b from the immediate
    logic      use_imm;
    // Operand a forced to zero, LUI only
    logic      zero_a;

    modport src (output vld, tid, alu_op, rs1, rs2, rd, imm, use_imm, zero_a);
    modport dst (input  vld, tid, alu_op, rs1, rs2, rd, imm, use_imm, zero_a);
endinterface

//////////////////////////////////////////////////
// Issue to execution
//////////////////////////////////////////////////
interface exe_if import barrel_pkg::*; ();
    logic    vld;
    tid_t    tid;
    reg_addr_t rd;
    alu_op_e alu_op;
    xlen_t   op_a;
    xlen_t   op_b;

    modport src (output vld, tid, rd, alu_op, op_a, op_b);
    modport dst (input  vld, tid, rd, alu_op, op_a, op_b);
endinterface

//////////////////////////////////////////////////
// Write-back to the register file
//////////////////////////////////////////////////
interface wb_if import barrel_pkg::*; ();
    logic      vld;
    tid_t      tid;
    reg_addr_t rd;
    xlen_t     data;

    modport src (output vld, tid, rd, data);
    modport dst (input  vld, tid, rd, data);
endinterface

// File: verilog/thread_rf.sv
`timescale 1ns/10ps
`include "barrel_macros.svh"

module thread_rf import barrel_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_down_w,
    input  tid_t      rd_tid_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    input  logic      wr_en_i,
    input  tid_t      wr_tid_i,
    input  reg_addr_t wr_rd_i,
    input  xlen_t     wr_data_i
);
    // One bank per thread
    xlen_t regs_q [`BC_NUM_THREADS][`BC_NUM_REGS];

    // Write at the edge, x0 never written
    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            for (int t = 0; t < `BC_NUM_THREADS; t++) begin
                for (int r = 0; r < `BC_NUM_REGS; r++) begin
                    regs_q[t][r] <= '0;
                end
            end
        end else if (wr_en_i && (wr_rd_i != '0)) begin
            regs_q[wr_tid_i][wr_rd_i] <= wr_data_i;
        end
    end

    // Combinational reads, x0 hardwired
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rd_tid_i][rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rd_tid_i][rs2_i];

endmodule

// File: verilog/alu_exec.sv
`timescale 1ns/10ps

module alu_exec import barrel_pkg::*; (
    input  logic clk_i,
    input  logic rst_down_w,
    exe_if.dst   exe,
    wb_if.src    wb
);
    logic [4:0] shamt_w;
    xlen_t      result_w;

    // Shifts see only the low 5 bits
    assign shamt_w = exe.op_b[4:0];

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////
    always_comb begin
        case (exe.alu_op)
            ALU_ADD:  result_w = exe.op_a + exe.op_b;
            ALU_SUB:  result_w = exe.op_a - exe.op_b;
            ALU_SLL:  result_w = exe.op_a << shamt_w;
            ALU_SLT:  result_w = xlen_t'($signed(exe.op_a) < $signed(exe.op_b));
            ALU_SLTU: result_w = xlen_t'(exe.op_a < exe.op_b);
            ALU_XOR:  result_w = exe.op_a ^ exe.op_b;
            ALU_SRL:  result_w = exe.op_a >> shamt_w;
            ALU_SRA:  result_w = xlen_t'($signed(exe.op_a) >>> shamt_w);
            ALU_OR:   result_w = exe.op_a | exe.op_b;
            ALU_AND:  result_w = exe.op_a & exe.op_b;
            default:  result_w = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Write-back register
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            wb.vld <= 1'b0;
        end else begin
            wb.vld <= exe.vld;
        end
    end

    always_ff @(posedge clk_i) begin
        wb.tid  <= exe.tid;
        wb.rd   <= exe.rd;
        wb.data <= result_w;
    end

    // Decode only ever issues the ten known operations
    a_alu_op_legal: assert property (@(posedge clk_i) disable iff (rst_down_w)
        exe.vld |-> exe.alu_op inside {[ALU_ADD:ALU_AND]});

endmodule

// File: verilog/issue_stage.sv
`timescale 1ns/10ps

module issue_stage import barrel_pkg::*; (
    input  logic clk_i,
    input  logic rst_down_w,
    dec_if.dst   dec,
    exe_if.src   exe,
    wb_if.dst    wb
);
    xlen_t rs1_data_w;
    xlen_t rs2_data_w;
    xlen_t op_a_w;
    xlen_t op_b_w;

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////

    // Read port follows decode, write port follows write-back
    thread_rf i_thread_rf (
        .clk_i      (clk_i),
        .rst_down_w (rst_down_w),
        .rd_tid_i   (dec.tid),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rs1_data_o (rs1_data_w),
        .rs2_data_o (rs2_data_w),
        .wr_en_i    (wb.vld),
        .wr_tid_i   (wb.tid),
        .wr_rd_i    (wb.rd),
        .wr_data_i  (wb.data)
    );

    // Operand select
    assign op_a_w = dec.zero_a  ? '0      : rs1_data_w;
    assign op_b_w = dec.use_imm ? dec.imm : rs2_data_w;

    //////////////////////////////////////////////////
    // Issue register
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            exe.vld <= 1'b0;
        end else begin
            exe.vld <= dec.vld;
        end
    end

    always_ff @(posedge clk_i) begin
        exe.tid    <= dec.tid;
        exe.rd     <= dec.rd;
        exe.alu_op <= dec.alu_op;
        exe.op_a   <= op_a_w;
        exe.op_b   <= op_b_w;
    end

    // Barrel spacing keeps write-back off the thread being read
    a_no_rf_hazard: assert property (@(posedge clk_i) disable iff (rst_down_w)
        dec.vld && wb.vld |-> dec.tid != wb.tid);

endmodule

// File: verilog/insn_decode.sv
`timescale 1ns/10ps
`include "barrel_macros.svh"

module insn_decode import barrel_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_down_w,
    input  logic  resp_vld_i,
    input  xlen_t insn_i,
    input  tid_t  tid_i,
    dec_if.src    dec
);
    opcode_e  opcode_w;
    logic [2:0] funct3_w;
    logic     dec_vld_w;
    alu_op_e  alu_op_w;
    xlen_t    imm_w;
    logic     use_imm_w;
    logic     zero_a_w;

    // Shared funct3 map for OP and OP_IMM
    function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  funct3_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  funct3_op = ALU_SLL;
            3'b010:  funct3_op = ALU_SLT;
            3'b011:  funct3_op = ALU_SLTU;
            3'b100:  funct3_op = ALU_XOR;
            3'b101:  funct3_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  funct3_op = ALU_OR;
            default: funct3_op = ALU_AND;
        endcase
    endfunction

    assign opcode_w = opcode_e'(insn_i[6:0]);
    assign funct3_w = insn_i[14:12];

    //////////////////////////////////////////////////
    // Field decode
    //////////////////////////////////////////////////
    always_comb begin
        dec_vld_w = 1'b0;
        alu_op_w  = ALU_ADD;
        imm_w     = '0;
        use_imm_w = 1'b0;
        zero_a_w  = 1'b0;
        case (opcode_w)
            OPC_OP: begin
                dec_vld_w = resp_vld_i;
                alu_op_w  = funct3_op(funct3_w, insn_i[30]);
            end
            OPC_OP_IMM: begin
                dec_vld_w = resp_vld_i;
                use_imm_w = 1'b1;
                // Bit 30 picks SRAI only since OP_IMM has no SUBI
                alu_op_w  = funct3_op(funct3_w, (funct3_w == 3'b101) && insn_i[30]);
                if (funct3_w == 3'b001 || funct3_w == 3'b101) begin
                    imm_w = xlen_t'(insn_i[24:20]);
                end else begin
                    imm_w = {{(`BC_XLEN - 12){insn_i[31]}}, insn_i[31:20]};
                end
            end
            OPC_LUI: begin
                dec_vld_w = resp_vld_i;
                use_imm_w = 1'b1;
                zero_a_w  = 1'b1;
                imm_w     = {insn_i[31:12], 12'b0};
            end
            // Anything else is dropped here
            default: dec_vld_w = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Decode register
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            dec.vld <= 1'b0;
        end else begin
            dec.vld <= dec_vld_w;
        end
    end

    always_ff @(posedge clk_i) begin
        dec.tid     <= tid_i;
        dec.alu_op  <= alu_op_w;
        dec.rs1     <= insn_i[19:15];
        dec.rs2     <= insn_i[24:20];
        dec.rd      <= insn_i[11:7];
        dec.imm     <= imm_w;
        dec.use_imm <= use_imm_w;
        dec.zero_a  <= zero_a_w;
    end

endmodule

// File: verilog/barrel_fetch.sv
`timescale 1ns/10ps
`include "barrel_macros.svh"

module barrel_fetch import barrel_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_down_w,
    input  logic  fetch_en_i,
    output logic  imem_req_vld_o,
    input  logic  imem_req_rdy_i,
    output pc_t   imem_req_addr_o,
    input  logic  imem_resp_vld_i,
    input  xlen_t imem_resp_data_i,
    output logic  resp_vld_o,
    output xlen_t insn_o,
    output tid_t  tid_o
);
    // Per-thread program counters
    pc_t  pc_q [`BC_NUM_THREADS];
    // Round-robin pointer, next thread to fetch
    tid_t rr_q;
    // One request in flight at most
    logic outst_q;
    tid_t outst_tid_q;
    // Raised but not yet accepted
    logic wait_q;
    logic accept_w;

    //////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////

    // A waiting request stays up even if fetch_en_i drops
    assign imem_req_vld_o  = !outst_q && (fetch_en_i || wait_q);
    assign imem_req_addr_o = pc_q[rr_q];
    assign accept_w        = imem_req_vld_o && imem_req_rdy_i;

    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            for (int t = 0; t < `BC_NUM_THREADS; t++) begin
                pc_q[t] <= pc_t'(t * `BC_PC_STRIDE);
            end
            rr_q        <= '0;
            outst_q     <= 1'b0;
            outst_tid_q <= '0;
            wait_q      <= 1'b0;
        end else begin
            wait_q <= imem_req_vld_o && !imem_req_rdy_i;
            if (accept_w) begin
                // Step PC and hand over to the next thread
                pc_q[rr_q]  <= pc_q[rr_q] + pc_t'(4);
                rr_q        <= (rr_q == tid_t'(`BC_NUM_THREADS - 1)) ? '0 : rr_q + 1'b1;
                outst_tid_q <= rr_q;
                outst_q     <= 1'b1;
            end else if (imem_resp_vld_i) begin
                outst_q <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Response side
    //////////////////////////////////////////////////

    // Tagged with the thread that asked for it
    assign resp_vld_o = imem_resp_vld_i && outst_q;
    assign insn_o     = imem_resp_data_i;
    assign tid_o      = outst_tid_q;

    // No response without a request in flight
    a_resp_outst: assert property (@(posedge clk_i) disable iff (rst_down_w)
        imem_resp_vld_i |-> outst_q);

    // Stalled request keeps its address
    a_addr_hold: assert property (@(posedge clk_i) disable iff (rst_down_w)
        imem_req_vld_o && !imem_req_rdy_i |=> imem_req_vld_o && $stable(imem_req_addr_o));

endmodule

// File: verilog/barrel_core.sv
`timescale 1ns/10ps

module barrel_core import barrel_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_down_w,
    input  logic      fetch_en_i,
    // Instruction memory
    output logic      imem_req_vld_o,
    input  logic      imem_req_rdy_i,
    output pc_t       imem_req_addr_o,
    input  logic      imem_resp_vld_i,
    input  xlen_t     imem_resp_data_i,
    // Retire report, one per register write
    output logic      retire_vld_o,
    output tid_t      retire_tid_o,
    output reg_addr_t retire_rd_o,
    output xlen_t     retire_data_o
);
    //////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////
    logic  fetch_vld_w;
    xlen_t fetch_insn_w;
    tid_t  fetch_tid_w;

    // Stage buses
    dec_if dec_bus ();
    exe_if exe_bus ();
    wb_if  wb_bus ();

    barrel_fetch i_barrel_fetch (
        .clk_i            (clk_i),
        .rst_down_w       (rst_down_w),
        .fetch_en_i       (fetch_en_i),
        .imem_req_vld_o   (imem_req_vld_o),
        .imem_req_rdy_i   (imem_req_rdy_i),
        .imem_req_addr_o  (imem_req_addr_o),
        .imem_resp_vld_i  (imem_resp_vld_i),
        .imem_resp_data_i (imem_resp_data_i),
        .resp_vld_o       (fetch_vld_w),
        .insn_o           (fetch_insn_w),
        .tid_o            (fetch_tid_w)
    );

    //////////////////////////////////////////////////
    // Decode, issue, execution
    //////////////////////////////////////////////////
    insn_decode i_insn_decode (
        .clk_i      (clk_i),
        .rst_down_w (rst_down_w),
        .resp_vld_i (fetch_vld_w),
        .insn_i     (fetch_insn_w),
        .tid_i      (fetch_tid_w),
        .dec        (dec_bus)
    );

    // Issue also owns the register file write
    issue_stage i_issue_stage (
        .clk_i      (clk_i),
        .rst_down_w (rst_down_w),
        .dec        (dec_bus),
        .exe        (exe_bus),
        .wb         (wb_bus)
    );

    alu_exec i_alu_exec (
        .clk_i      (clk_i),
        .rst_down_w (rst_down_w),
        .exe        (exe_bus),
        .wb         (wb_bus)
    );

    // Retire mirrors the write-back
    assign retire_vld_o  = wb_bus.vld;
    assign retire_tid_o  = wb_bus.tid;
    assign retire_rd_o   = wb_bus.rd;
    assign retire_data_o = wb_bus.data;

endmodule

// File: testbench/tb_barrel_core.sv
`timescale 1ns/10ps
`include "barrel_macros.svh"

module tb_barrel_core import barrel_pkg::*; ();
    localparam int RST_CYCLES    = 16;
    localparam int RETIRE_TARGET = 2000;
    localparam int MAX_CYCLES    = 40000;
    localparam int IDLE_LIMIT    = 500;
    // RV32I major opcodes
    localparam logic [6:0] OPC_R = 7'b0110011;
    localparam logic [6:0] OPC_I = 7'b0010011;
    localparam logic [6:0] OPC_U = 7'b0110111;

    // Expected retire, due on a given cycle
    typedef struct packed {
        int        due;
        tid_t      tid;
        reg_addr_t rd;
        xlen_t     data;
    } exp_t;

    logic      clk_i;
    logic      rst_down_w;
    logic      fetch_en_i;
    logic      imem_req_vld_o;
    logic      imem_req_rdy_i;
    pc_t       imem_req_addr_o;
    logic      imem_resp_vld_i;
    xlen_t     imem_resp_data_i;
    logic      retire_vld_o;
    tid_t      retire_tid_o;
    reg_addr_t retire_rd_o;
    xlen_t     retire_data_o;

    // Reference model state
    pc_t         m_pc [`BC_NUM_THREADS];
    xlen_t       m_rf [`BC_NUM_THREADS][`BC_NUM_REGS];
    tid_t        m_rr;
    exp_t        exp_q [$];
    logic [15:0] lfsr_q;

    barrel_core i_barrel_core (
        .clk_i            (clk_i),
        .rst_down_w       (rst_down_w),
        .fetch_en_i       (fetch_en_i),
        .imem_req_vld_o   (imem_req_vld_o),
        .imem_req_rdy_i   (imem_req_rdy_i),
        .imem_req_addr_o  (imem_req_addr_o),
        .imem_resp_vld_i  (imem_resp_vld_i),
        .imem_resp_data_i (imem_resp_data_i),
        .retire_vld_o     (retire_vld_o),
        .retire_tid_o     (retire_tid_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // Random word, about one in eight unsupported
    function automatic xlen_t gen_insn();
        logic [2:0] kind;
        logic [2:0] f3;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       alt;
        logic [6:0] opc;
        xlen_t      word;
        kind = 3'(rand_bits(3));
        rd   = 5'(rand_bits(5));
        rs1  = 5'(rand_bits(5));
        rs2  = 5'(rand_bits(5));
        f3   = 3'(rand_bits(3));
        alt  = 1'(rand_bits(1)) && (f3 == 3'b000 || f3 == 3'b101);
        if (kind == 3'd0) begin
            opc = 7'(rand_bits(7));
            // Bit 6 set moves a supported opcode out of the set
            if (opc == OPC_R || opc == OPC_I || opc == OPC_U) begin
                opc = opc ^ 7'h40;
            end
            word = {25'(rand_bits(25)), opc};
        end else if (kind <= 3'd3) begin
            word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_R};
        end else if (kind <= 3'd6) begin
            if (f3 == 3'b001) begin
                word = {7'b0, rs2, rs1, f3, rd, OPC_I};
            end else if (f3 == 3'b101) begin
                word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_I};
            end else begin
                word = {12'(rand_bits(12)), rs1, f3, rd, OPC_I};
            end
        end else begin
            word = {20'(rand_bits(20)), rd, OPC_U};
        end
        return word;
    endfunction

    // RV32I integer semantics by funct3
    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  alu_ref = alt ? a - b : a + b;
            3'b001:  alu_ref = a << b[4:0];
            3'b010:  alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  alu_ref = (a < b) ? 32'd1 : 32'd0;
            3'b100:  alu_ref = a ^ b;
            3'b101:  alu_ref = alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    // Execute one word in the model, queue its retire
    task automatic model_apply(input tid_t t, input xlen_t insn, input int due);
        logic [2:0] f3;
        logic       alt;
        logic       ok;
        reg_addr_t  rd;
        xlen_t      a;
        xlen_t      b;
        exp_t       e;
        f3  = insn[14:12];
        rd  = insn[11:7];
        a   = m_rf[t][insn[19:15]];
        b   = m_rf[t][insn[24:20]];
        alt = insn[30];
        ok  = 1'b1;
        case (insn[6:0])
            OPC_R: ok = 1'b1;
            OPC_I: begin
                // No SUBI, bit 30 only marks SRAI
                alt = (f3 == 3'b101) && insn[30];
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    b = xlen_t'(insn[24:20]);
                end else begin
                    b = {{20{insn[31]}}, insn[31:20]};
                end
            end
            OPC_U: begin
                f3  = 3'b000;
                alt = 1'b0;
                a   = '0;
                b   = {insn[31:12], 12'b0};
            end
            default: ok = 1'b0;
        endcase
        if (ok) begin
            e.due  = due;
            e.tid  = t;
            e.rd   = rd;
            e.data = alu_ref(f3, alt, a, b);
            // x0 stays zero in the model
            if (rd != 5'd0) begin
                m_rf[t][rd] = e.data;
            end
            exp_q.push_back(e);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////
    initial begin
        int    cyc;
        int    retired;
        int    last_ret;
        int    en_low_cnt;
        int    delay_cnt;
        logic  pending;
        logic  m_wait;
        logic  exp_req;
        logic  resp_now;
        tid_t  pend_tid;
        xlen_t pend_insn;
        exp_t  e;
        rst_down_w       = 1'b1;
        fetch_en_i       = 1'b0;
        imem_req_rdy_i   = 1'b0;
        imem_resp_vld_i  = 1'b0;
        imem_resp_data_i = '0;
        lfsr_q           = 16'd2167;
        for (int t = 0; t < `BC_NUM_THREADS; t++) begin
            m_pc[t] = pc_t'(t * `BC_PC_STRIDE);
            for (int r = 0; r < `BC_NUM_REGS; r++) begin
                m_rf[t][r] = '0;
            end
        end
        m_rr       = '0;
        cyc        = 0;
        retired    = 0;
        last_ret   = 0;
        en_low_cnt = 6;
        delay_cnt  = 0;
        pending    = 1'b0;
        m_wait     = 1'b0;
        pend_tid   = '0;
        pend_insn  = '0;

        // Quiet outputs throughout reset
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(negedge clk_i);
            #1;
            assert (!imem_req_vld_o && !retire_vld_o)
                else fail_run("Request or retire strobe active during reset");
        end
        rst_down_w = 1'b0;

        while (retired < RETIRE_TARGET && cyc < MAX_CYCLES) begin
            @(negedge clk_i);
            // Random stretches with fetch disabled
            if (en_low_cnt > 0) begin
                fetch_en_i = 1'b0;
                en_low_cnt--;
            end else if (rand_bits(6) == 32'd0) begin
                fetch_en_i = 1'b0;
                en_low_cnt = 3 + int'(rand_bits(4));
            end else begin
                fetch_en_i = 1'b1;
            end
            imem_req_rdy_i   = 1'(rand_bits(1));
            resp_now         = pending && (delay_cnt == 0);
            imem_resp_vld_i  = resp_now;
            imem_resp_data_i = resp_now ? pend_insn : '0;
            #1;

            // Fetch port, one request at a time
            exp_req = !pending && (fetch_en_i || m_wait);
            assert (imem_req_vld_o == exp_req)
                else fail_run($sformatf("Mismatch imem_req_vld_o: got 0x%0h expected 0x%0h",
                                        imem_req_vld_o, exp_req));
            if (exp_req) begin
                assert (imem_req_addr_o == m_pc[m_rr])
                    else fail_run($sformatf("Mismatch imem_req_addr_o: got 0x%08h expected 0x%08h",
                                            imem_req_addr_o, m_pc[m_rr]));
            end

            // Retire port, exact cycle
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                e = exp_q.pop_front();
                assert (retire_vld_o)
                    else fail_run("Mismatch retire_vld_o: got 0x0 expected 0x1");
                assert (retire_tid_o == e.tid)
                    else fail_run($sformatf("Mismatch retire_tid_o: got 0x%0h expected 0x%0h",
                                            retire_tid_o, e.tid));
                assert (retire_rd_o == e.rd)
                    else fail_run($sformatf("Mismatch retire_rd_o: got 0x%02h expected 0x%02h",
                                            retire_rd_o, e.rd));
                assert (retire_data_o == e.data)
                    else fail_run($sformatf("Mismatch retire_data_o: got 0x%08h expected 0x%08h",
                                            retire_data_o, e.data));
                retired++;
                last_ret = cyc;
            end else begin
                assert (!retire_vld_o)
                    else fail_run("Mismatch retire_vld_o: got 0x1 expected 0x0");
            end
            assert (cyc - last_ret <= IDLE_LIMIT)
                else fail_run($sformatf("No instruction retired for %0d cycles", IDLE_LIMIT));

            // Model update for the coming edge
            if (resp_now) begin
                pending = 1'b0;
                model_apply(pend_tid, pend_insn, cyc + 3);
            end else if (pending) begin
                delay_cnt--;
            end
            m_wait = exp_req && !imem_req_rdy_i;
            if (exp_req && imem_req_rdy_i) begin
                pending   = 1'b1;
                pend_tid  = m_rr;
                pend_insn = gen_insn();
                delay_cnt = int'(rand_bits(2));
                m_pc[m_rr] = m_pc[m_rr] + 32'd4;
                m_rr      = tid_t'((int'(m_rr) + 1) % `BC_NUM_THREADS);
            end
            cyc++;
        end

        if (retired < RETIRE_TARGET) begin
            fail_run($sformatf("Timeout after %0d cycles with %0d instructions retired",
                               cyc, retired));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: barrel_core.f
+incdir+include
verilog/barrel_pkg.sv
verilog/barrel_if.sv
verilog/thread_rf.sv
verilog/alu_exec.sv
verilog/issue_stage.sv
verilog/insn_decode.sv
verilog/barrel_fetch.sv
verilog/barrel_core.sv
testbench/tb_barrel_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_barrel_core
RTL_TOP   ?= barrel_core
FILELIST  ?= barrel_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
